// ==== Makefile ====
# Verilator build and run for the hex display testbench

VERILATOR ?= verilator
TOP       ?= tb_hex_display
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       ?= $(OBJ_DIR)/V$(TOP)
PASS_TEXT ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_hex_display.sv ====
// Hex display subsystem testbench

`timescale 1ns/100ps

module tb_hex_display;

    localparam int scan        = 8;                               // shortened refresh
    localparam int frame       = display_pkg::w_digit * scan;     // one full scan
    localparam int hold_cycles = 4;                               // press and release length
    localparam int n_load      = 4;
    localparam int n_wrap      = 4;
    localparam int n_dot       = 6;
    localparam int n_prio      = 4;
    localparam int n_mix       = 3;
    localparam int mix_len     = 6;

    localparam int planned_presses =
        n_load + n_wrap + n_dot + 2 + n_prio + n_mix * mix_len;
    localparam int timeout_cycles = planned_presses * 80 + 2000;

    logic                              clk;
    logic                              rst;
    logic [display_pkg::n_keys  - 1:0] key;
    logic [display_pkg::w_value - 1:0] sw;
    logic [7:0]                        abcdefgh;
    logic [display_pkg::w_digit - 1:0] digit;

    integer                            seed;
    logic [display_pkg::w_value - 1:0] model_value;   // what the display should show
    logic [display_pkg::w_digit - 1:0] model_dots;
    logic                              settled;       // display has caught up with the model
    int                                windows;
    int                                seg_checks;
    int                                cycles = 0;
    logic [display_pkg::w_digit - 1:0] digit_q;       // strobe seen on the previous edge
    int                                held;          // edges the strobe has stayed put
    logic                              stepped;

    hex_display_top #(
        .scan_cycles (scan)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    function automatic logic [15:0] rand16();
        return 16'($random(seed));
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [display_pkg::n_keys - 1:0] key_bit(input int idx);
        return display_pkg::n_keys'(1) << idx;
    endfunction

    // lit segments of each hex digit, by letter
    function automatic logic [7:0] font_pattern(input logic [3:0] nib);
        string      lit;
        byte        letter;
        logic [7:0] seg;
        case (nib)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcfg";
            4'ha: lit = "abcefg";
            4'hb: lit = "cdefg";
            4'hc: lit = "adef";
            4'hd: lit = "bcdeg";
            4'he: lit = "adefg";
            default: lit = "aefg";
        endcase
        seg = '0;
        for (int i = 0; i < lit.len(); i++) begin
            letter = lit[i];
            seg[7 - (int'(letter) - 97)] = 1'b1;     // a lands on bit 7
        end
        return seg;
    endfunction

    function automatic logic [7:0] expected_segments(input int pos);
        return font_pattern(model_value[pos * 4 +: 4]) ^ {7'b0, model_dots[pos]};
    endfunction

    function automatic int onehot_index(input logic [display_pkg::w_digit - 1:0] strobe);
        int pos;
        pos = 0;
        for (int i = 0; i < display_pkg::w_digit; i++) begin
            if (strobe[i]) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // lowest index wins when keys rise together
    function automatic int lowest_key(input logic [display_pkg::n_keys - 1:0] keys);
        for (int i = 0; i < display_pkg::n_keys; i++) begin
            if (keys[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic apply_model(input int op_index, input logic [15:0] operand);
        case (op_index)
            0: model_value = model_value + 16'd1;
            1: model_value = model_value - 16'd1;
            2: model_value = operand;
            3: begin
                model_value = '0;
                model_dots  = '0;
            end
            default: model_dots[operand[1:0]] = ~model_dots[operand[1:0]];
        endcase
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic press_keys(input logic [display_pkg::n_keys - 1:0] keys,
                              input logic [display_pkg::w_value - 1:0] operand);
        settled = 1'b0;                              // display may lag from here on
        apply_model(lowest_key(keys), operand);
        key = keys;
        sw  = operand;
        wait_cycles(hold_cycles);
        key = '0;                                    // sw stays, it is sampled with the key
        wait_cycles(hold_cycles);
    endtask

    task automatic settle_window();
        wait_cycles(frame);                          // new value reaches every digit
        settled = 1'b1;
        windows = windows + 1;
        wait_cycles(frame);                          // one full scan under check
    endtask

    always @(posedge clk) begin : scan_check
        int                                pos;
        logic [7:0]                        want;
        logic [display_pkg::w_digit - 1:0] want_digit;
        if (rst) begin
            digit_q    <= '0;
            held       <= 0;
            stepped    <= 1'b0;
            seg_checks <= 0;
        end else if (digit != digit_q) begin
            if (digit_q == '0) begin
                a_first: assert (digit == display_pkg::w_digit'(1))
                    else report_mismatch("digit", 32'(digit), 32'd1);
            end else begin
                want_digit = {digit_q[display_pkg::w_digit - 2:0],
                              digit_q[display_pkg::w_digit - 1]};   // one place up
                a_order: assert (digit == want_digit)
                    else report_mismatch("digit", 32'(digit), 32'(want_digit));
                a_dwell: assert (held == scan)
                    else report_mismatch("digit dwell cycles", 32'(held), 32'(scan));
            end
            if (settled) begin
                pos  = onehot_index(digit);
                want = expected_segments(pos);
                a_seg: assert (abcdefgh == want)
                    else report_mismatch($sformatf("abcdefgh at digit %0d", pos),
                                         32'(abcdefgh), 32'(want));
                seg_checks <= seg_checks + 1;
            end
            held    <= 1;
            stepped <= 1'b1;
            digit_q <= digit;
        end else begin
            if (!stepped) begin
                a_idle: assert (digit == '0 && abcdefgh == '0)
                    else report_problem("display lit before the first scan step");
            end
            held <= held + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            report_problem($sformatf("timeout, tests did not finish in %0d cycles",
                                     timeout_cycles));
        end
    end

    initial begin
        int first;
        int second;
        clk         = 1'b0;
        rst         = 1'b1;
        key         = '0;
        sw          = '0;
        seed        = 32'h7138_1197;
        model_value = '0;
        model_dots  = '0;
        settled     = 1'b0;
        windows     = 0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        settle_window();                             // reset state

        for (int i = 0; i < n_load; i++) begin
            press_keys(key_bit(int'(display_pkg::op_load)), rand16());
            settle_window();
        end

        // wrap from ffff to 0 and back
        press_keys(key_bit(int'(display_pkg::op_load)), 16'hfffe);
        press_keys(key_bit(int'(display_pkg::op_inc)), rand16());
        settle_window();
        press_keys(key_bit(int'(display_pkg::op_inc)), rand16());
        settle_window();
        press_keys(key_bit(int'(display_pkg::op_dec)), rand16());
        settle_window();

        press_keys(key_bit(int'(display_pkg::op_load)), rand16());
        for (int i = 0; i < n_dot; i++) begin
            press_keys(key_bit(int'(display_pkg::op_dot)), rand16());
        end
        settle_window();
        press_keys(key_bit(int'(display_pkg::op_clear)), rand16());
        settle_window();                             // back to the reset picture

        // two keys rising on the same edge
        for (int i = 0; i < n_prio; i++) begin
            first  = rand_below(display_pkg::n_keys);
            second = (first + 1 + rand_below(display_pkg::n_keys - 1)) % display_pkg::n_keys;
            press_keys(key_bit(first) | key_bit(second), rand16());
            settle_window();
        end

        for (int b = 0; b < n_mix; b++) begin
            for (int i = 0; i < mix_len; i++) begin
                press_keys(key_bit(rand_below(display_pkg::n_keys)), rand16());
            end
            settle_window();
        end

        $display("%0d display checks in %0d windows", seg_checks, windows);
        if (seg_checks < windows * display_pkg::w_digit) begin
            report_problem("fewer display checks than the settle windows need");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== include/segment_font.svh ====
// Hex digit segment font

// segment order is a b c d e f g h, msb first
//
//      a
//    f   b
//      g
//    e   c
//      d   h
//
// h is the decimal point and is never lit by the font itself

function automatic logic [7:0] dig_to_seg(input logic [3:0] dig);
    logic [7:0] seg;
    case (dig)
        4'h0: seg = 8'b1111_1100;
        4'h1: seg = 8'b0110_0000;
        4'h2: seg = 8'b1101_1010;
        4'h3: seg = 8'b1111_0010;
        4'h4: seg = 8'b0110_0110;
        4'h5: seg = 8'b1011_0110;
        4'h6: seg = 8'b1011_1110;
        4'h7: seg = 8'b1110_0000;
        4'h8: seg = 8'b1111_1110;
        4'h9: seg = 8'b1110_0110;
        4'ha: seg = 8'b1110_1110;
        4'hb: seg = 8'b0011_1110;               // lower case b
        4'hc: seg = 8'b1001_1100;
        4'hd: seg = 8'b0111_1010;               // lower case d
        4'he: seg = 8'b1001_1110;
        default: seg = 8'b1000_1110;            // 4'hf
    endcase
    return seg;
endfunction

// ==== src/display_pkg.sv ====
// Hex display shared definitions

package display_pkg;

    localparam int w_digit = 4;                    // digits on the board
    localparam int w_value = w_digit * 4;          // one nibble per digit
    localparam int w_index = $clog2(w_digit);      // digit position select
    localparam int n_keys  = 5;                    // command push buttons

    // 50 MHz clock, 4 digits, 16 Hz full refresh
    localparam int clk_hz              = 50_000_000;
    localparam int refresh_hz          = 16;
    localparam int default_scan_cycles = clk_hz / w_digit / refresh_hz;

    // key index order, key 0 is op_inc
    typedef enum logic [2:0] {
        op_inc   = 3'd0,
        op_dec   = 3'd1,
        op_load  = 3'd2,
        op_clear = 3'd3,
        op_dot   = 3'd4
    } op_t;

    typedef struct packed {
        logic                 valid;                // one cycle per press
        op_t                  op;
        logic [w_value - 1:0] operand;              // switches at press time
    } cmd_t;

endpackage

// ==== src/hex_display_top.sv ====
// Hex entry and display top

`timescale 1ns/100ps

module hex_display_top #(
    parameter int scan_cycles = display_pkg::default_scan_cycles
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [display_pkg::n_keys  - 1:0]  key,
    input  logic [display_pkg::w_value - 1:0]  sw,
    output logic [7:0]                         abcdefgh,
    output logic [display_pkg::w_digit - 1:0]  digit
);

    display_pkg::cmd_t                 cmd;
    logic [display_pkg::w_value - 1:0] value;
    logic [display_pkg::w_digit - 1:0] dots;

    key_decoder u_decoder (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .sw   (sw),
        .cmd  (cmd)
    );

    value_unit u_value (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .value (value),
        .dots  (dots)
    );

    seven_segment_display #(
        .scan_cycles (scan_cycles)
    ) u_display (
        .clk      (clk),
        .rst      (rst),
        .number   (value),
        .dots     (dots),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

// ==== src/key_decoder.sv ====
// Key press decoder

`timescale 1ns/100ps

module key_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [display_pkg::n_keys  - 1:0]  key,
    input  logic [display_pkg::w_value - 1:0]  sw,
    output display_pkg::cmd_t                  cmd
);

    logic [display_pkg::n_keys  - 1:0] key_meta;   // first sync stage
    logic [display_pkg::n_keys  - 1:0] key_sync;   // second sync stage
    logic [display_pkg::n_keys  - 1:0] key_prev;   // level one cycle back
    logic [display_pkg::n_keys  - 1:0] key_rise;
    logic [display_pkg::w_value - 1:0] sw_meta;
    logic [display_pkg::w_value - 1:0] sw_sync;
    logic                              pressed;
    display_pkg::op_t                  sel_op;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    // switches ride the same two stages so the operand lines up with the key
    always_ff @(posedge clk) begin
        sw_meta <= sw;
        sw_sync <= sw_meta;
    end

    assign key_rise = key_sync & ~key_prev;
    assign pressed  = |key_rise;

    // scan from the top down so the lowest risen key is left in sel_op
    always_comb begin
        sel_op = display_pkg::op_inc;
        for (int i = display_pkg::n_keys - 1; i >= 0; i--) begin
            if (key_rise[i]) begin
                sel_op = display_pkg::op_t'(3'(i));
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd.valid   <= pressed;                 // high for the edge cycle only
            cmd.op      <= sel_op;
            cmd.operand <= sw_sync;
        end
    end

endmodule

// ==== src/seven_segment_display.sv ====
// Multiplexed seven segment driver

`timescale 1ns/100ps

module seven_segment_display #(
    parameter int scan_cycles = display_pkg::default_scan_cycles
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [display_pkg::w_value - 1:0]  number,
    input  logic [display_pkg::w_digit - 1:0]  dots,
    output logic [7:0]                         abcdefgh,
    output logic [display_pkg::w_digit - 1:0]  digit
);

    `include "segment_font.svh"

    localparam int w_cnt = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;

    logic [w_cnt - 1:0]                cnt;     // cycles spent on this digit
    logic [display_pkg::w_index - 1:0] index;   // next position to light
    logic                              step;
    logic [3:0]                        nibble;
    logic                              last_index;

    assign step       = (cnt == w_cnt'(scan_cycles - 1));
    assign nibble     = number[index * 4 +: 4];
    assign last_index = (index == display_pkg::w_index'(display_pkg::w_digit - 1));

    // segments and strobe change together so no ghosting between digits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            index    <= '0;
            abcdefgh <= '0;
            digit    <= '0;
        end else if (step) begin
            cnt      <= '0;
            index    <= last_index ? '0 : index + display_pkg::w_index'(1);
            abcdefgh <= dig_to_seg(nibble) ^ {7'b0, dots[index]};   // dot on bit 0
            digit    <= display_pkg::w_digit'(1) << index;
        end else begin
            cnt <= cnt + w_cnt'(1);
        end
    end

endmodule

// ==== src/value_unit.sv ====
// Displayed value and dot register

`timescale 1ns/100ps

module value_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  display_pkg::cmd_t                  cmd,
    output logic [display_pkg::w_value - 1:0]  value,
    output logic [display_pkg::w_digit - 1:0]  dots
);

    logic [display_pkg::w_value - 1:0] value_next;
    logic [display_pkg::w_digit - 1:0] dots_next;
    logic [display_pkg::w_index - 1:0] dot_sel;

    assign dot_sel = cmd.operand[display_pkg::w_index - 1:0];   // position modulo 4

    always_comb begin
        value_next = value;
        dots_next  = dots;
        if (cmd.valid) begin
            case (cmd.op)
                display_pkg::op_inc: begin
                    value_next = value + display_pkg::w_value'(1);  // wraps at ffff
                end
                display_pkg::op_dec: begin
                    value_next = value - display_pkg::w_value'(1);  // wraps at 0
                end
                display_pkg::op_load: begin
                    value_next = cmd.operand;
                end
                display_pkg::op_clear: begin
                    value_next = '0;
                    dots_next  = '0;
                end
                display_pkg::op_dot: begin
                    dots_next[dot_sel] = ~dots[dot_sel];
                end
                default: begin
                    value_next = value;                 // unused codes hold
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= '0;
            dots  <= '0;
        end else begin
            value <= value_next;
            dots  <= dots_next;
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
src/display_pkg.sv
src/key_decoder.sv
src/value_unit.sv
src/seven_segment_display.sv
src/hex_display_top.sv
bench/tb_hex_display.sv
